// File: verilog/bus_pkg.sv
`default_nettype none

// ----------------------------------------------------------------------
// CPU data bus widths and vector types
// ----------------------------------------------------------------------
package bus_pkg;

    localparam int DBUS_ADDR_W = 32;
    localparam int DBUS_DATA_W = 32;
    localparam int DBUS_STRB_W = DBUS_DATA_W / 8;  // One enable per byte lane

    // Byte address on the data bus
    typedef logic [DBUS_ADDR_W-1:0] dbus_addr_t;

    // One data word
    typedef logic [DBUS_DATA_W-1:0] dbus_word_t;

    // Byte write enables that leave memory untouched when all zero
    typedef logic [DBUS_STRB_W-1:0] dbus_strb_t;

endpackage

`default_nettype wire

// File: verilog/axi_pkg.sv
`default_nettype none

// ----------------------------------------------------------------------
// AXI payload types and channel positions
// ----------------------------------------------------------------------
package axi_pkg;

    localparam int AXI_ADDR_W = 32;
    localparam int AXI_DATA_W = 32;

    typedef logic [AXI_ADDR_W-1:0]   axi_addr_t;
    typedef logic [AXI_DATA_W-1:0]   axi_data_t;
    typedef logic [AXI_DATA_W/8-1:0] axi_strb_t;

    // Bit positions in the bridge's pending-channel vector
    localparam int CH_AR = 4;
    localparam int CH_R  = 3;
    localparam int CH_AW = 2;
    localparam int CH_W  = 1;
    localparam int CH_B  = 0;

endpackage

`default_nettype wire

// File: verilog/sram_array.sv
`timescale 1ns/1ns
`default_nettype none

module sram_array #(
    parameter int DEPTH = 256
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] idx,
    input  logic                     we,
    input  bus_pkg::dbus_strb_t      wstrb,
    input  bus_pkg::dbus_word_t      wdata,
    output bus_pkg::dbus_word_t      rdata
);
    import bus_pkg::*;

    localparam int N_BYTES = DBUS_DATA_W / 8;

    dbus_word_t mem [DEPTH];

    // Only the enabled byte lanes change
    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < N_BYTES; b++) begin
                if (wstrb[b])
                    mem[idx][8*b +: 8] <= wdata[8*b +: 8];
            end
        end
    end

    // The read word appears the cycle after idx
    always_ff @(posedge clk) begin
        rdata <= mem[idx];
    end

endmodule

`default_nettype wire

// File: verilog/axi_sram_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module axi_sram_ctrl #(
    parameter int DEPTH = 256
) (
    input  logic                       clk,
    input  logic                       resetn,

    // AXI slave side
    input  logic                       arvalid,
    output logic                       arready,
    input  axi_pkg::axi_addr_t         araddr,
    output logic                       rvalid,
    input  logic                       rready,
    output axi_pkg::axi_data_t         rdata,
    input  logic                       awvalid,
    output logic                       awready,
    input  axi_pkg::axi_addr_t         awaddr,
    input  logic                       wvalid,
    output logic                       wready,
    input  axi_pkg::axi_data_t         wdata,
    input  axi_pkg::axi_strb_t         wstrb,
    output logic                       bvalid,
    input  logic                       bready,

    // Array side
    output logic [$clog2(DEPTH)-1:0]   mem_addr,
    output logic                       mem_we,
    output axi_pkg::axi_strb_t         mem_wstrb,
    output axi_pkg::axi_data_t         mem_wdata,
    input  axi_pkg::axi_data_t         mem_rdata
);
    import axi_pkg::*;

    localparam int IDX_W = $clog2(DEPTH);

    typedef enum logic [2:0] {
        IDLE,
        READ,
        RESP_R,
        WRITE,
        RESP_B
    } sram_ctrl_state_t;

    sram_ctrl_state_t state;
    sram_ctrl_state_t state_next;

    logic             ar_hs;
    logic             aw_hs;
    logic             w_hs;
    logic             aw_held;
    logic             w_held;
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    axi_data_t        wdata_q;
    axi_strb_t        wstrb_q;

    // ------------------------------------------------------------------
    // Channel acceptance
    // ------------------------------------------------------------------
    assign arready = (state == IDLE);
    assign awready = (state == IDLE) && !aw_held && !arvalid;  // A pending read goes first
    assign wready  = (state == IDLE) && !w_held && !arvalid;

    assign ar_hs = arvalid && arready;
    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (ar_hs)
                    state_next = READ;
                else if ((aw_held || aw_hs) && (w_held || w_hs))
                    state_next = WRITE;
            end
            READ:    state_next = RESP_R;
            RESP_R:  if (rready) state_next = IDLE;
            WRITE:   state_next = bready ? IDLE : RESP_B;
            RESP_B:  if (bready) state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            state   <= IDLE;
            aw_held <= 1'b0;
            w_held  <= 1'b0;
        end else begin
            state <= state_next;
            if (aw_hs)
                aw_held <= 1'b1;
            else if (state == WRITE)
                aw_held <= 1'b0;
            if (w_hs)
                w_held <= 1'b1;
            else if (state == WRITE)
                w_held <= 1'b0;
        end
    end

    // Word index drops the byte offset, so addresses wrap modulo DEPTH
    always_ff @(posedge clk) begin
        if (ar_hs)
            rd_idx <= araddr[IDX_W+1:2];
        if (aw_hs)
            wr_idx <= awaddr[IDX_W+1:2];
        if (w_hs) begin
            wdata_q <= wdata;
            wstrb_q <= wstrb;
        end
    end

    // ------------------------------------------------------------------
    // Array drive and responses
    // ------------------------------------------------------------------
    assign mem_addr  = (state == WRITE) ? wr_idx : rd_idx;
    assign mem_we    = (state == WRITE);  // Exactly one write per AW/W pair
    assign mem_wstrb = wstrb_q;
    assign mem_wdata = wdata_q;

    assign rvalid = (state == RESP_R);
    assign rdata  = mem_rdata;          // Array keeps rereading rd_idx while R stalls
    assign bvalid = (state == WRITE) || (state == RESP_B);

endmodule

`default_nettype wire

// File: verilog/dbus_to_axi.sv
`timescale 1ns/1ns
`default_nettype none

module dbus_to_axi (
    input  logic                clk,
    input  logic                resetn,

    // CPU data bus
    input  logic                req,
    input  logic                wr,
    input  bus_pkg::dbus_addr_t addr,
    input  bus_pkg::dbus_strb_t wstrb,
    input  bus_pkg::dbus_word_t wdata,
    output logic                addr_ok,
    output logic                data_ok,
    output bus_pkg::dbus_word_t rdata,

    // AXI master side
    output logic                arvalid,
    input  logic                arready,
    output axi_pkg::axi_addr_t  araddr,
    input  logic                rvalid,
    output logic                rready,
    input  axi_pkg::axi_data_t  axi_rdata,
    output logic                awvalid,
    input  logic                awready,
    output axi_pkg::axi_addr_t  awaddr,
    output logic                wvalid,
    input  logic                wready,
    output axi_pkg::axi_data_t  axi_wdata,
    output axi_pkg::axi_strb_t  axi_wstrb,
    input  logic                bvalid,
    output logic                bready
);
    import bus_pkg::*;
    import axi_pkg::*;

    logic [4:0] pending;      // One bit per channel still owed
    logic [4:0] handshake;
    logic [4:0] issue_set;
    logic       busy;

    dbus_addr_t saved_addr;
    dbus_strb_t saved_strb;
    dbus_word_t saved_wdata;

    // ------------------------------------------------------------------
    // Channel bookkeeping
    // ------------------------------------------------------------------
    assign busy = |pending;

    always_comb begin
        issue_set = '0;
        if (wr) begin
            issue_set[CH_AW] = 1'b1;
            issue_set[CH_W]  = 1'b1;
            issue_set[CH_B]  = 1'b1;
        end else begin
            issue_set[CH_AR] = 1'b1;
            issue_set[CH_R]  = 1'b1;
        end
    end

    always_comb begin
        handshake        = '0;
        handshake[CH_AR] = pending[CH_AR] && arready;
        handshake[CH_R]  = pending[CH_R]  && rvalid;
        handshake[CH_AW] = pending[CH_AW] && awready;
        handshake[CH_W]  = pending[CH_W]  && wready;
        handshake[CH_B]  = pending[CH_B]  && bvalid;
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            pending <= '0;
        end else if (busy) begin
            pending <= pending & ~handshake;  // Each handshake retires its channel
        end else if (req) begin
            pending <= issue_set;
        end
    end

    // Request copy stays put while channels are in flight
    always_ff @(posedge clk) begin
        if (!busy) begin
            saved_addr  <= addr;
            saved_strb  <= wstrb;
            saved_wdata <= wdata;
        end
    end

    // ------------------------------------------------------------------
    // Data bus responses
    // ------------------------------------------------------------------
    assign addr_ok = !busy;
    assign data_ok = handshake[CH_W] || handshake[CH_R];
    assign rdata   = dbus_word_t'(axi_rdata);

    // ------------------------------------------------------------------
    // AXI valids and readies driven from the pending bits
    // ------------------------------------------------------------------
    assign arvalid   = pending[CH_AR];
    assign araddr    = axi_addr_t'(saved_addr);
    assign rready    = pending[CH_R];

    assign awvalid   = pending[CH_AW];
    assign awaddr    = axi_addr_t'(saved_addr);
    assign wvalid    = pending[CH_W];
    assign axi_wdata = axi_data_t'(saved_wdata);
    assign axi_wstrb = axi_strb_t'(saved_strb);
    assign bready    = pending[CH_B];

endmodule

`default_nettype wire

// File: verilog/mem_subsys_top.sv
`timescale 1ns/1ns
`default_nettype none

module mem_subsys_top #(
    parameter int DEPTH = 256
) (
    input  logic                clk,
    input  logic                resetn,
    input  logic                req,
    input  logic                wr,
    input  bus_pkg::dbus_addr_t addr,
    input  bus_pkg::dbus_strb_t wstrb,
    input  bus_pkg::dbus_word_t wdata,
    output logic                addr_ok,
    output logic                data_ok,
    output bus_pkg::dbus_word_t rdata
);
    import axi_pkg::*;

    localparam int IDX_W = $clog2(DEPTH);

    // ------------------------------------------------------------------
    // AXI link between bridge and slave
    // ------------------------------------------------------------------
    logic      arvalid;
    logic      arready;
    axi_addr_t araddr;
    logic      rvalid;
    logic      rready;
    axi_data_t axi_rdata;
    logic      awvalid;
    logic      awready;
    axi_addr_t awaddr;
    logic      wvalid;
    logic      wready;
    axi_data_t axi_wdata;
    axi_strb_t axi_wstrb;
    logic      bvalid;
    logic      bready;

    // Array port
    logic [IDX_W-1:0] mem_addr;
    logic             mem_we;
    axi_strb_t        mem_wstrb;
    axi_data_t        mem_wdata;
    axi_data_t        mem_rdata;

    dbus_to_axi u_bridge (
        .clk       (clk),
        .resetn    (resetn),
        .req       (req),
        .wr        (wr),
        .addr      (addr),
        .wstrb     (wstrb),
        .wdata     (wdata),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .arvalid   (arvalid),
        .arready   (arready),
        .araddr    (araddr),
        .rvalid    (rvalid),
        .rready    (rready),
        .axi_rdata (axi_rdata),
        .awvalid   (awvalid),
        .awready   (awready),
        .awaddr    (awaddr),
        .wvalid    (wvalid),
        .wready    (wready),
        .axi_wdata (axi_wdata),
        .axi_wstrb (axi_wstrb),
        .bvalid    (bvalid),
        .bready    (bready)
    );

    axi_sram_ctrl #(
        .DEPTH (DEPTH)
    ) u_ctrl (
        .clk       (clk),
        .resetn    (resetn),
        .arvalid   (arvalid),
        .arready   (arready),
        .araddr    (araddr),
        .rvalid    (rvalid),
        .rready    (rready),
        .rdata     (axi_rdata),
        .awvalid   (awvalid),
        .awready   (awready),
        .awaddr    (awaddr),
        .wvalid    (wvalid),
        .wready    (wready),
        .wdata     (axi_wdata),
        .wstrb     (axi_wstrb),
        .bvalid    (bvalid),
        .bready    (bready),
        .mem_addr  (mem_addr),
        .mem_we    (mem_we),
        .mem_wstrb (mem_wstrb),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    sram_array #(
        .DEPTH (DEPTH)
    ) u_array (
        .clk   (clk),
        .idx   (mem_addr),
        .we    (mem_we),
        .wstrb (mem_wstrb),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

endmodule

`default_nettype wire

// File: verif/tb_mem_subsys.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mem_subsys;
    import bus_pkg::*;

    localparam int DEPTH          = 256;
    localparam int IDX_W          = $clog2(DEPTH);
    localparam int TIMEOUT_CYCLES = 2500;  // About 340 requests at up to 4 cycles each, plus margin

    logic       clk = 1'b0;
    logic       resetn;
    logic       req;
    logic       wr;
    dbus_addr_t addr;
    dbus_strb_t wstrb;
    dbus_word_t wdata;
    logic       addr_ok;
    logic       data_ok;
    dbus_word_t rdata;

    dbus_word_t       model [DEPTH];
    bit               written [DEPTH];
    logic [IDX_W-1:0] written_list [$];
    dbus_word_t       exp_q [$];
    logic [31:0]      rng = 32'd93683;
    int               cycle_cnt = 0;
    int               accept_cnt = 0;
    int               done_cnt = 0;
    logic             inflight = 1'b0;
    logic             inflight_rd = 1'b0;

    mem_subsys_top #(
        .DEPTH (DEPTH)
    ) u_dut (
        .clk     (clk),
        .resetn  (resetn),
        .req     (req),
        .wr      (wr),
        .addr    (addr),
        .wstrb   (wstrb),
        .wdata   (wdata),
        .addr_ok (addr_ok),
        .data_ok (data_ok),
        .rdata   (rdata)
    );

    initial begin
        forever #20 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // Reporting, random source and reference model
    // ------------------------------------------------------------------
    task automatic stop_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        stop_run($sformatf("Fail %s expected 0x%h got 0x%h", name, expected, actual));
    endtask

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // Word index is the byte address divided by four, wrapped to the array size
    function automatic dbus_word_t ref_access(input logic is_wr, input dbus_addr_t a,
                                              input dbus_strb_t s, input dbus_word_t d);
        logic [IDX_W-1:0] i;
        i = IDX_W'((a >> 2) % DEPTH);
        if (is_wr) begin
            for (int b = 0; b < 4; b++) begin
                if (s[b])
                    model[i][8*b +: 8] = d[8*b +: 8];
            end
            if (s == 4'hf && !written[i]) begin
                written[i] = 1'b1;              // Readable once every byte is known
                written_list.push_back(i);
            end
        end
        return model[i];
    endfunction

    // ------------------------------------------------------------------
    // Data bus driver that holds req high until data_ok
    // ------------------------------------------------------------------
    task automatic bus_access(input logic is_wr, input dbus_addr_t a, input dbus_strb_t s,
                              input dbus_word_t d);
        dbus_word_t expv;
        @(negedge clk);
        req   = 1'b1;
        wr    = is_wr;
        addr  = a;
        wstrb = s;
        wdata = d;
        @(posedge clk);
        while (!addr_ok) @(posedge clk);
        expv = ref_access(is_wr, a, s, d);
        if (!is_wr)
            exp_q.push_back(expv);
        @(posedge clk);
        while (!data_ok) @(posedge clk);
    endtask

    task automatic write_word(input dbus_addr_t a, input dbus_strb_t s, input dbus_word_t d);
        bus_access(1'b1, a, s, d);
    endtask

    task automatic read_word(input dbus_addr_t a);
        bus_access(1'b0, a, 4'h0, 32'h0);
    endtask

    task automatic bus_idle(input int n);
        @(negedge clk);
        req = 1'b0;
        repeat (n) @(posedge clk);
    endtask

    // ------------------------------------------------------------------
    // Compare process and timeout
    // ------------------------------------------------------------------
    always @(posedge clk) begin
        if (!resetn) begin
            if (data_ok) begin
                assert (inflight) else stop_run("data_ok arrived with no request outstanding");
                done_cnt = done_cnt + 1;
                if (inflight_rd) begin
                    assert (rdata === exp_q[0]) else report_mismatch("rdata", exp_q[0], rdata);
                    void'(exp_q.pop_front());
                end
                inflight = 1'b0;
            end
            if (req && addr_ok) begin
                accept_cnt  = accept_cnt + 1;
                inflight    = 1'b1;
                inflight_rd = !wr;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
            stop_run($sformatf("Run timed out after %0d cycles with AR=%b R=%b AW=%b W=%b B=%b",
                     cycle_cnt,
                     u_dut.u_bridge.pending[axi_pkg::CH_AR],
                     u_dut.u_bridge.pending[axi_pkg::CH_R],
                     u_dut.u_bridge.pending[axi_pkg::CH_AW],
                     u_dut.u_bridge.pending[axi_pkg::CH_W],
                     u_dut.u_bridge.pending[axi_pkg::CH_B]));
    end

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial begin
        logic [31:0]      r;
        logic [31:0]      r2;
        logic [IDX_W-1:0] idx;
        dbus_strb_t       strb;

        resetn = 1'b1;
        req    = 1'b0;
        wr     = 1'b0;
        addr   = '0;
        wstrb  = '0;
        wdata  = '0;
        repeat (3) @(negedge clk);
        resetn = 1'b0;

        @(posedge clk);  // First cycle out of reset
        assert (addr_ok === 1'b1) else report_mismatch("addr_ok", 32'd1, 32'(addr_ok));
        assert (data_ok === 1'b0) else report_mismatch("data_ok", 32'd0, 32'(data_ok));

        for (int i = 0; i < 16; i++)
            write_word(32'h0000_0100 + 32'(i * 4), 4'hf, next_rand());
        for (int i = 0; i < 16; i++)
            read_word(32'h0000_0100 + 32'(i * 4));
        bus_idle(2);

        write_word(32'h0000_0040, 4'hf, 32'h1122_3344);
        write_word(32'h0000_0040, 4'h1, 32'hAAAA_AAAA);
        read_word(32'h0000_0040);
        write_word(32'h0000_0040, 4'h4, 32'h5555_5555);
        write_word(32'h0000_0040, 4'hc, 32'hDEAD_BEEF);  // Upper half word
        read_word(32'h0000_0040);
        write_word(32'h0000_0040, 4'h0, 32'hFFFF_FFFF);
        read_word(32'h0000_0040);
        bus_idle(2);

        write_word(32'h0000_0080 + 32'(4 * DEPTH), 4'hf, 32'hCAFE_F00D);
        read_word(32'h0000_0080);
        bus_idle(2);

        for (int n = 0; n < 300; n++) begin
            r  = next_rand();
            r2 = next_rand();
            if (r[0] || written_list.size() == 0) begin
                idx  = r[8 +: IDX_W];
                strb = written[idx] ? r[7:4] : 4'hf;
                write_word({r2[31:IDX_W+2], idx, 2'b00}, strb, next_rand());
            end else begin
                idx = written_list[(r >> 1) % written_list.size()];
                read_word({r2[31:IDX_W+2], idx, 2'b00});
            end
        end
        bus_idle(4);

        assert (done_cnt == accept_cnt) begin
            $display("all tests passed");
            $finish;
        end else begin
            report_mismatch("data_ok count", 32'(accept_cnt), 32'(done_cnt));
        end
    end

endmodule

`default_nettype wire

// File: sources.f
verilog/bus_pkg.sv
verilog/axi_pkg.sv
verilog/sram_array.sv
verilog/axi_sram_ctrl.sv
verilog/dbus_to_axi.sv
verilog/mem_subsys_top.sv
verif/tb_mem_subsys.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mem_subsys \
    -f sources.f -o sim_mem_subsys || exit 1

out=$(./obj_dir/sim_mem_subsys)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "all tests passed" && exit 0 || exit 1
